// File: hci_mux_ooo.sv
`timescale 1ns/100ps

module hci_mux_ooo (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      clear_i,
  input  logic                                      priority_force_i,
  input  hci_pkg::prio_t    [hci_pkg::NB_CHAN-1:0]  priority_i,
  input  hci_pkg::hci_req_t [hci_pkg::NB_CHAN-1:0]  chan_req,
  output logic              [hci_pkg::NB_CHAN-1:0]  chan_gnt,
  output hci_pkg::hci_rsp_t [hci_pkg::NB_CHAN-1:0]  chan_rsp,
  input  logic              [hci_pkg::NB_CHAN-1:0]  chan_r_ready,
  output hci_pkg::hci_id_req_t                      mem_req,
  input  logic                                      mem_gnt,
  input  hci_pkg::hci_id_rsp_t                      mem_rsp,
  output logic                                      mem_r_ready
);
  import hci_pkg::*;

  // round-robin state
  prio_t                rr_cnt_q;
  // priority slot vector, position 0 is served first
  prio_t [NB_CHAN-1:0]  slot_d;
  prio_t                winner_d;
  // per-channel strobes padded to the full id range
  logic  [NB_ID-1:0]    req_vec;
  logic  [NB_ID-1:0]    rdy_vec;
  // memory-side request handshake
  logic                 mem_hs;

  assign mem_hs = mem_req.base.req & mem_gnt;

  // counter advances once per accepted request, wraps at NB_CHAN
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      rr_cnt_q <= '0;
    end else if (clear_i) begin
      rr_cnt_q <= '0;
    end else if (mem_hs) begin
      if (rr_cnt_q == prio_t'(NB_CHAN - 1)) begin
        rr_cnt_q <= '0;
      end else begin
        rr_cnt_q <= rr_cnt_q + prio_t'(1);
      end
    end
  end

  // gather strobes, unused ids stay at 0
  always_comb begin
    req_vec = '0;
    rdy_vec = '0;
    for (int c = 0; c < NB_CHAN; c++) begin
      req_vec[c] = chan_req[c].req;
      rdy_vec[c] = chan_r_ready[c];
    end
  end

  for (genvar ii = 0; ii < NB_CHAN; ii++) begin : gen_chan
    // forced slot from outside, else rotate by the counter
    assign slot_d[ii] = priority_force_i ? priority_i[ii]
                                         : prio_t'((rr_cnt_q + ii) % NB_CHAN);

    // only the winner sees the memory grant
    assign chan_gnt[ii] = (winner_d == ii) & chan_req[ii].req & mem_gnt;

    // data goes to everyone, valid only to the channel named by r_id
    assign chan_rsp[ii].r_valid = (mem_rsp.r_id == ii) & mem_rsp.base.r_valid;
    assign chan_rsp[ii].r_data  = mem_rsp.base.r_data;
  end

  // winner-takes-all over the slot vector
  // scanned from the back so the lowest requesting position overrides
  always_comb begin : wta_comb
    winner_d = rr_cnt_q;
    for (int k = NB_CHAN - 1; k >= 0; k--) begin
      if (req_vec[slot_d[k]]) begin
        winner_d = slot_d[k];
      end
    end
  end

  // forward the winning request, tagged with its channel index
  // with nobody requesting the counter channel is idle, so req stays 0
  assign mem_req.base = chan_req[winner_d];
  assign mem_req.id   = winner_d;

  // back-pressure comes from the channel owning the current response
  assign mem_r_ready = rdy_vec[mem_rsp.r_id];

endmodule

// File: hci_pkg.sv
package hci_pkg;

  // number of initiator channels sharing the bank
  localparam int unsigned NB_CHAN = 3;
  // channel id width, enough to name every channel
  localparam int unsigned ID_W = $clog2(NB_CHAN);
  // full id range, used to pad per-channel vectors to a power of two
  localparam int unsigned NB_ID = 2 ** ID_W;

  // data width in bits
  localparam int unsigned DW = 32;
  // word address width, 256 words
  localparam int unsigned AW = 8;
  // one byte enable per data byte
  localparam int unsigned BW = DW / 8;

  // priority slot value, one per channel
  typedef logic [ID_W-1:0] prio_t;

  // initiator request, tcdm style
  typedef struct packed {
    logic          req;
    logic [AW-1:0] add;
    // 1 = read, 0 = write
    logic          wen;
    logic [DW-1:0] data;
    logic [BW-1:0] be;
  } hci_req_t;

  // request tagged with the source channel, memory side of the mux
  typedef struct packed {
    hci_req_t        base;
    logic [ID_W-1:0] id;
  } hci_id_req_t;

  // response towards an initiator
  typedef struct packed {
    logic          r_valid;
    logic [DW-1:0] r_data;
  } hci_rsp_t;

  // response carrying back the id of the request it answers
  typedef struct packed {
    hci_rsp_t        base;
    logic [ID_W-1:0] r_id;
  } hci_id_rsp_t;

endpackage

// File: hci_r_id_filter.sv
`timescale 1ns/100ps

module hci_r_id_filter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  hci_pkg::hci_id_req_t  in_req,
  output logic                  in_gnt,
  output hci_pkg::hci_id_rsp_t  in_rsp,
  input  logic                  in_r_ready,
  output hci_pkg::hci_req_t     bank_req,
  input  logic                  bank_gnt,
  input  hci_pkg::hci_rsp_t     bank_rsp,
  output logic                  bank_r_ready
);
  import hci_pkg::*;

  // id of the last accepted request
  logic [ID_W-1:0] id_q;

  // bank never sees the id
  assign bank_req = in_req.base;
  assign in_gnt   = bank_gnt;

  // capture on handshake, the bank answers exactly one request later
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      id_q <= '0;
    end else if (in_req.base.req && bank_gnt) begin
      id_q <= in_req.id;
    end
  end

  // bank holds gnt low while a response waits,
  // so id_q stays matched to the pending response
  assign in_rsp.base = bank_rsp;
  assign in_rsp.r_id = id_q;

  assign bank_r_ready = in_r_ready;

endmodule

// File: project.f
hci_pkg.sv
hci_mux_ooo.sv
hci_r_id_filter.sv
tcdm_bank.sv
tcdm_subsystem.sv
tcdm_subsystem_tb.sv

// File: tcdm_bank.sv
`timescale 1ns/100ps

module tcdm_bank (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  hci_pkg::hci_req_t  req,
  output logic               gnt,
  output hci_pkg::hci_rsp_t  rsp,
  input  logic               r_ready
);
  import hci_pkg::*;

  // word storage
  logic [DW-1:0] mem_q [2**AW];
  // registered response
  logic          rvalid_q;
  logic [DW-1:0] rdata_q;
  // current word with enabled bytes replaced
  logic [DW-1:0] wdata_merged;
  logic          hs;

  // stall while the previous response has not been taken
  assign gnt = req.req & ~(rvalid_q & ~r_ready);
  assign hs  = req.req & gnt;

  // byte-enable merge against the addressed word
  always_comb begin
    wdata_merged = mem_q[req.add];
    for (int b = 0; b < BW; b++) begin
      if (req.be[b]) begin
        wdata_merged[b*8 +: 8] = req.data[b*8 +: 8];
      end
    end
  end

  // one response per accepted request and held until r_ready
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else if (hs) begin
      rvalid_q <= 1'b1;
    end else if (r_ready) begin
      rvalid_q <= 1'b0;
    end
  end

  // array and read data
  always_ff @(posedge clk_i) begin
    if (hs) begin
      if (req.wen) begin
        rdata_q <= mem_q[req.add];
      end else begin
        mem_q[req.add] <= wdata_merged;
        // writes return the updated word
        rdata_q        <= wdata_merged;
      end
    end
  end

  assign rsp.r_valid = rvalid_q;
  assign rsp.r_data  = rdata_q;

endmodule

// File: tcdm_subsystem.sv
`timescale 1ns/100ps

module tcdm_subsystem (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      clear_i,
  input  logic                                      priority_force_i,
  input  hci_pkg::prio_t    [hci_pkg::NB_CHAN-1:0]  priority_i,
  input  hci_pkg::hci_req_t [hci_pkg::NB_CHAN-1:0]  chan_req,
  output logic              [hci_pkg::NB_CHAN-1:0]  chan_gnt,
  output hci_pkg::hci_rsp_t [hci_pkg::NB_CHAN-1:0]  chan_rsp,
  input  logic              [hci_pkg::NB_CHAN-1:0]  chan_r_ready
);
  import hci_pkg::*;

  // mux to id filter
  hci_id_req_t mem_req;
  logic        mem_gnt;
  hci_id_rsp_t mem_rsp;
  logic        mem_r_ready;

  // id filter to bank
  hci_req_t    bank_req;
  logic        bank_gnt;
  hci_rsp_t    bank_rsp;
  logic        bank_r_ready;

  hci_mux_ooo u_mux (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .clear_i          (clear_i),
    .priority_force_i (priority_force_i),
    .priority_i       (priority_i),
    .chan_req         (chan_req),
    .chan_gnt         (chan_gnt),
    .chan_rsp         (chan_rsp),
    .chan_r_ready     (chan_r_ready),
    .mem_req          (mem_req),
    .mem_gnt          (mem_gnt),
    .mem_rsp          (mem_rsp),
    .mem_r_ready      (mem_r_ready)
  );

  // zero-latency boundary, ids reflected here
  hci_r_id_filter u_id_filter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_req       (mem_req),
    .in_gnt       (mem_gnt),
    .in_rsp       (mem_rsp),
    .in_r_ready   (mem_r_ready),
    .bank_req     (bank_req),
    .bank_gnt     (bank_gnt),
    .bank_rsp     (bank_rsp),
    .bank_r_ready (bank_r_ready)
  );

  tcdm_bank u_bank (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req     (bank_req),
    .gnt     (bank_gnt),
    .rsp     (bank_rsp),
    .r_ready (bank_r_ready)
  );

endmodule

// File: tcdm_subsystem_tb.sv
`timescale 1ns/100ps

module tcdm_subsystem_tb;
  import hci_pkg::*;

  // one table row, a step runs until granted or for a fixed number of cycles
  typedef struct packed {
    logic [NB_CHAN-1:0]  req;
    logic [AW-1:0]       add;
    logic                wen;
    logic [BW-1:0]       be;
    logic                force_on;
    prio_t [NB_CHAN-1:0] prio;
    logic                clear;
    logic [NB_CHAN-1:0]  rdy;
    logic [3:0]          hold;
    logic [NB_CHAN-1:0]  exp_gnt;
  } step_t;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        clear_i;
  logic                        priority_force_i;
  prio_t    [NB_CHAN-1:0]      priority_i;
  hci_req_t [NB_CHAN-1:0]      chan_req;
  logic     [NB_CHAN-1:0]      chan_gnt;
  hci_rsp_t [NB_CHAN-1:0]      chan_rsp;
  logic     [NB_CHAN-1:0]      chan_r_ready;

  // stimulus table
  step_t       steps[$];
  string       step_names[$];

  // reference model state
  logic [DW-1:0] ref_mem [2**AW];
  logic [DW-1:0] chan_data [NB_CHAN];
  int            rr_cnt;
  logic          m_valid;
  int            m_id;
  logic [DW-1:0] m_data;
  integer        seed;
  int            max_wait;

  tcdm_subsystem u_tcdm_subsystem (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .clear_i          (clear_i),
    .priority_force_i (priority_force_i),
    .priority_i       (priority_i),
    .chan_req         (chan_req),
    .chan_gnt         (chan_gnt),
    .chan_rsp         (chan_rsp),
    .chan_r_ready     (chan_r_ready)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_gnt(input string name, input logic [NB_CHAN-1:0] exp,
                           input logic [NB_CHAN-1:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("FAIL %s: gnt expected %b, actual %b", name, exp, act));
    end
  endtask

  // data only matters while the response is valid
  task automatic check_rsp(input string name, input hci_rsp_t exp, input hci_rsp_t act);
    if (act.r_valid !== exp.r_valid || (exp.r_valid && act.r_data !== exp.r_data)) begin
      stop_with_failure($sformatf("FAIL %s: rsp expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic add_step(input string name, input logic [NB_CHAN-1:0] req,
                          input logic [AW-1:0] add, input logic wen, input logic [BW-1:0] be,
                          input logic force_on, input prio_t [NB_CHAN-1:0] prio,
                          input logic clear, input logic [NB_CHAN-1:0] rdy,
                          input logic [3:0] hold, input logic [NB_CHAN-1:0] exp_gnt);
    steps.push_back({req, add, wen, be, force_on, prio, clear, rdy, hold, exp_gnt});
    step_names.push_back(name);
  endtask

  // winner rule: first requesting channel over slot positions 0..NB_CHAN-1
  function automatic int predict_winner(input logic [NB_CHAN-1:0] req, input logic force_on,
                                        input prio_t [NB_CHAN-1:0] prio, input int cnt);
    int slot;
    int win;
    logic found;
    win = cnt;
    found = 1'b0;
    for (int k = 0; k < NB_CHAN; k++) begin
      slot = force_on ? int'(prio[k]) : (cnt + k) % NB_CHAN;
      if (!found && slot < NB_CHAN && req[slot]) begin
        win = slot;
        found = 1'b1;
      end
    end
    return win;
  endfunction

  // channel c uses the row address plus c
  task automatic drive_inputs(input step_t st);
    for (int c = 0; c < NB_CHAN; c++) begin
      chan_req[c].req  = st.req[c];
      chan_req[c].add  = st.add + AW'(c);
      chan_req[c].wen  = st.wen;
      chan_req[c].data = chan_data[c];
      chan_req[c].be   = st.be;
    end
    clear_i          = st.clear;
    priority_force_i = st.force_on;
    priority_i       = st.prio;
    chan_r_ready     = st.rdy;
  endtask

  // one clock: drive on falling edge, check before the rising edge, advance model
  task automatic run_cycle(input step_t st, input string name,
                           output logic [NB_CHAN-1:0] gnt_seen);
    logic [NB_CHAN-1:0] exp_gnt;
    hci_rsp_t           exp_rsp;
    logic [DW-1:0]      merged;
    logic [AW-1:0]      add_w;
    int                 win;
    @(negedge clk_i);
    drive_inputs(st);
    #1;
    win = predict_winner(st.req, st.force_on, st.prio, rr_cnt);
    exp_gnt = '0;
    // bank stalls while its response waits on the owner's r_ready
    if (st.req[win] && !(m_valid && !st.rdy[m_id])) begin
      exp_gnt[win] = 1'b1;
    end
    check_gnt(name, exp_gnt, chan_gnt);
    for (int c = 0; c < NB_CHAN; c++) begin
      exp_rsp.r_valid = m_valid && (m_id == c);
      exp_rsp.r_data  = m_data;
      check_rsp(name, exp_rsp, chan_rsp[c]);
    end
    gnt_seen = chan_gnt;
    if (|exp_gnt) begin
      add_w  = st.add + AW'(win);
      merged = ref_mem[add_w];
      for (int b = 0; b < BW; b++) begin
        if (st.be[b]) begin
          merged[b*8 +: 8] = chan_data[win][b*8 +: 8];
        end
      end
      // wen 0 is a write, answered with the updated word
      if (!st.wen) begin
        ref_mem[add_w] = merged;
        m_data         = merged;
      end else begin
        m_data = ref_mem[add_w];
      end
      m_valid        = 1'b1;
      m_id           = win;
      chan_data[win] = $random(seed);
    end else if (m_valid && st.rdy[m_id]) begin
      m_valid = 1'b0;
    end
    if (st.clear) begin
      rr_cnt = 0;
    end else if (|exp_gnt) begin
      rr_cnt = (rr_cnt + 1) % NB_CHAN;
    end
  endtask

  task automatic build_table();
    add_step("idle", 3'b000, 8'h00, 1'b1, 4'h0, 1'b0, 6'h0, 1'b0, 3'b111, 4'd1, 3'b000);
    // round-robin from reset, each channel writes its own word
    add_step("rr_0", 3'b111, 8'h20, 1'b0, 4'hf, 1'b0, 6'h0, 1'b0, 3'b111, 4'd0, 3'b001);
    add_step("rr_1", 3'b111, 8'h20, 1'b0, 4'hf, 1'b0, 6'h0, 1'b0, 3'b111, 4'd0, 3'b010);
    add_step("rr_2", 3'b111, 8'h20, 1'b0, 4'hf, 1'b0, 6'h0, 1'b0, 3'b111, 4'd0, 3'b100);
    add_step("rr_3", 3'b111, 8'h20, 1'b0, 4'hf, 1'b0, 6'h0, 1'b0, 3'b111, 4'd0, 3'b001);
    // forced slots, reads route each channel's word back by id
    add_step("force_a", 3'b111, 8'h20, 1'b1, 4'h0, 1'b1, {2'd1, 2'd0, 2'd2}, 1'b0,
             3'b111, 4'd0, 3'b100);
    add_step("force_b", 3'b011, 8'h20, 1'b1, 4'h0, 1'b1, {2'd0, 2'd1, 2'd2}, 1'b0,
             3'b111, 4'd0, 3'b010);
    add_step("force_c", 3'b111, 8'h20, 1'b1, 4'h0, 1'b1, {2'd0, 2'd2, 2'd1}, 1'b0,
             3'b111, 4'd0, 3'b010);
    // response of channel 1 held, nothing granted
    add_step("bp_stall", 3'b111, 8'h20, 1'b1, 4'h0, 1'b0, 6'h0, 1'b0, 3'b000, 4'd4, 3'b000);
    add_step("bp_resume_a", 3'b111, 8'h20, 1'b1, 4'h0, 1'b0, 6'h0, 1'b0, 3'b111, 4'd0, 3'b010);
    add_step("bp_resume_b", 3'b111, 8'h20, 1'b1, 4'h0, 1'b0, 6'h0, 1'b0, 3'b111, 4'd0, 3'b100);
    // only the owner (channel 2) holds r_ready low
    add_step("bp_owner", 3'b111, 8'h20, 1'b1, 4'h0, 1'b0, 6'h0, 1'b0, 3'b011, 4'd3, 3'b000);
    add_step("bp_owner_done", 3'b111, 8'h20, 1'b1, 4'h0, 1'b0, 6'h0, 1'b0, 3'b111, 4'd0,
             3'b001);
    // counter is 1 here, clear brings it back to 0
    add_step("clear", 3'b000, 8'h20, 1'b1, 4'h0, 1'b0, 6'h0, 1'b1, 3'b111, 4'd1, 3'b000);
    add_step("after_clear", 3'b111, 8'h20, 1'b1, 4'h0, 1'b0, 6'h0, 1'b0, 3'b111, 4'd0, 3'b001);
    // single channel, full then partial writes, then read back
    add_step("wr_full_a", 3'b001, 8'h40, 1'b0, 4'hf, 1'b0, 6'h0, 1'b0, 3'b111, 4'd0, 3'b001);
    add_step("wr_full_b", 3'b001, 8'h41, 1'b0, 4'hf, 1'b0, 6'h0, 1'b0, 3'b111, 4'd0, 3'b001);
    add_step("wr_part_a", 3'b001, 8'h40, 1'b0, 4'h5, 1'b0, 6'h0, 1'b0, 3'b111, 4'd0, 3'b001);
    add_step("wr_part_b", 3'b001, 8'h41, 1'b0, 4'ha, 1'b0, 6'h0, 1'b0, 3'b111, 4'd0, 3'b001);
    add_step("rd_a", 3'b001, 8'h40, 1'b1, 4'h0, 1'b0, 6'h0, 1'b0, 3'b111, 4'd0, 3'b001);
    add_step("rd_b", 3'b001, 8'h41, 1'b1, 4'h0, 1'b0, 6'h0, 1'b0, 3'b111, 4'd0, 3'b001);
    add_step("drain", 3'b000, 8'h00, 1'b1, 4'h0, 1'b0, 6'h0, 1'b0, 3'b111, 4'd2, 3'b000);
  endtask

  // watchdog for the whole run
  initial begin
    #2000;
    stop_with_failure("timeout: simulation did not reach the end of the table");
  end

  initial begin
    logic [NB_CHAN-1:0] gnt_seen;
    int                 n;
    seed             = 97;
    max_wait         = 16;
    rst_ni           = 1'b0;
    clear_i          = 1'b0;
    priority_force_i = 1'b0;
    priority_i       = '0;
    chan_req         = '0;
    chan_r_ready     = '0;
    rr_cnt           = 0;
    m_valid          = 1'b0;
    m_id             = 0;
    m_data           = '0;
    for (int c = 0; c < NB_CHAN; c++) begin
      chan_data[c] = $random(seed);
    end
    build_table();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    for (int i = 0; i < steps.size(); i++) begin
      if (steps[i].hold == 0) begin
        // bounded wait for the grant of this step
        n = 0;
        gnt_seen = '0;
        while (gnt_seen == '0) begin
          if (n == max_wait) begin
            stop_with_failure($sformatf("timeout: no grant arrived in step %s",
                                        step_names[i]));
          end
          run_cycle(steps[i], step_names[i], gnt_seen);
          n++;
        end
        check_gnt(step_names[i], steps[i].exp_gnt, gnt_seen);
      end else begin
        repeat (steps[i].hold) begin
          run_cycle(steps[i], step_names[i], gnt_seen);
          check_gnt(step_names[i], steps[i].exp_gnt, gnt_seen);
        end
      end
    end
    $display("Simulation passed");
    $finish;
  end

endmodule
